//--- Bender.yml
package:
  name: uart_core

sources:
  - files:
      - rtl/uart_pkg.sv
      - rtl/serial_rx.sv
      - rtl/serial_tx.sv
      - rtl/rx_fifo.sv
      - rtl/uart_core.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_uart.sv

//--- dv/tb_clock.sv
// clock and reset source for the uart testbench
// 40 ns clock, reset held high for the first 8 rising edges

module tb_clock (
  output logic clk,    // free running clock
  output logic reset   // sync, active high
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // half of the 40 ns period
  end

  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;  // released on an edge, like any other input
  end

endmodule : tb_clock

//--- dv/tb_uart.sv
// testbench for uart_core that sends frames on rx, reads them back from the FIFO,
// samples the tx line at mid-bit and checks break, false start and overflow
// read data is checked by a separate process against a queue of expected bytes

module tb_uart;

  timeunit 1ns;
  timeprecision 1ps;

  import uart_pkg::*;

  logic        clk;
  logic        reset;
  logic        rx;
  logic        tx;
  logic [7:0]  tx_data;
  logic        tx_start;
  logic        tx_busy;
  logic [7:0]  rd_data;
  logic        rd_valid;
  logic        rd_en;
  logic        line_break;
  logic        overflow;

  logic [31:0] lfsr;            // random source state
  logic [7:0]  expected_q[$];   // bytes the FIFO should still hand out

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  uart_core u_dut (
    .clk        (clk),
    .reset      (reset),
    .rx         (rx),
    .tx         (tx),
    .tx_data    (tx_data),
    .tx_start   (tx_start),
    .tx_busy    (tx_busy),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .rd_en      (rd_en),
    .line_break (line_break),
    .overflow   (overflow)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic random_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  // expected line frame with start bit, data lsb first and stop bit
  function automatic logic [9:0] expected_frame(input logic [7:0] b);
    logic [9:0] f;
    f[0] = 1'b0;
    for (int i = 0; i < 8; i++)
      f[i + 1] = b[i];
    f[9] = 1'b1;
    return f;
  endfunction

  // byte a receiver recovers from a good frame
  function automatic logic [7:0] expected_byte(input logic [9:0] f);
    return f[8:1];
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
      fail_now($sformatf("error at %0d ns: %s is %0h, expected %0h",
                         $time, name, got, want));
  endtask

  // one frame on rx at 16 clocks per bit with a chosen stop level
  task automatic send_frame(input logic [7:0] b, input logic stop_level);
    logic [9:0] f;
    f    = expected_frame(b);
    f[9] = stop_level;
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      rx <= f[i];
      repeat (bit_period - 1) @(posedge clk);
    end
  endtask

  task automatic receive_byte(input logic [7:0] b);
    send_frame(b, 1'b1);
    expected_q.push_back(expected_byte(expected_frame(b)));
  endtask

  task automatic idle_line(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      rx <= 1'b1;
    end
  endtask

  // pop n bytes for the compare process to check
  task automatic read_bytes(input int n);
    int waited;
    for (int k = 0; k < n; k++)
    begin
      waited = 0;
      @(negedge clk);
      while (!rd_valid && (waited < 20 * bit_period))
      begin
        @(negedge clk);
        waited++;
      end
      if (!rd_valid)
        fail_now("no received byte showed up at the FIFO head in time");
      @(posedge clk);
      rd_en <= 1'b1;  // one pop
      @(posedge clk);
      rd_en <= 1'b0;
    end
    @(negedge clk);
    check("rd_valid", rd_valid, 1'b0);
    check("bytes left to read", expected_q.size(), 0);
  endtask

  // start a frame and sample tx mid-bit while counting busy cycles
  task automatic check_transmit(input logic [7:0] b);
    logic [9:0] want;
    logic [9:0] seen;
    logic       done;
    int         c;
    want = expected_frame(b);
    seen = '1;
    done = 1'b0;
    c    = 0;
    @(posedge clk);
    tx_data  <= b;
    tx_start <= 1'b1;
    @(posedge clk);  // taken on this edge
    tx_start <= 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (!tx_busy)
        done = 1'b1;
      else
      begin
        if (((c % bit_period) == 7) && (c < 10 * bit_period))
          seen[c / bit_period] = tx;  // mid-bit sample
        @(posedge clk);
        tx_start <= (c == 3 * bit_period);  // stray start while busy
        if (c == 3 * bit_period)
          tx_data <= ~b;
        c++;
        if (c > 20 * bit_period)
          fail_now("transmitter still busy long after the frame should have ended");
      end
    end
    check("tx frame", seen, want);
    check("tx_busy cycles", c, 10 * bit_period);
    for (int i = 0; i < 2 * bit_period; i++)
    begin
      @(negedge clk);
      check("tx_busy", tx_busy, 1'b0);  // stray start left no frame behind
      check("tx", tx, 1'b1);
    end
  endtask

  // every pop is compared with the oldest expected byte
  always @(negedge clk)
  begin : compare_reads
    logic [7:0] want;
    if (!reset && rd_en && rd_valid)
    begin
      if (expected_q.size() == 0)
        fail_now("the FIFO handed out a byte that was never sent");
      want = expected_q.pop_front();
      check("rd_data", rd_data, want);
    end
  end

  initial
  begin : scenarios
    logic [7:0] b;
    int         waited;
    rx       <= 1'b1;
    tx_data  <= '0;
    tx_start <= 1'b0;
    rd_en    <= 1'b0;
    lfsr     = 32'h5566a0b6;
    waited   = 0;
    @(posedge clk);
    while (reset && (waited < 100))
    begin
      @(posedge clk);
      waited++;
    end
    if (reset)
      fail_now("reset was never released");
    @(negedge clk);
    check("tx", tx, 1'b1);  // values out of reset
    check("tx_busy", tx_busy, 1'b0);
    check("line_break", line_break, 1'b0);
    check("overflow", overflow, 1'b0);
    check("rd_valid", rd_valid, 1'b0);

    // transmit random bytes
    for (int i = 0; i < 3; i++)
    begin
      random_byte(b);
      check_transmit(b);
    end

    // single receive
    random_byte(b);
    receive_byte(b);
    read_bytes(1);

    // burst that fills the FIFO exactly
    for (int i = 0; i < fifo_depth; i++)
    begin
      random_byte(b);
      receive_byte(b);
    end
    @(negedge clk);
    check("overflow", overflow, 1'b0);
    read_bytes(fifo_depth);

    // low stop bit
    random_byte(b);
    send_frame(b, 1'b0);
    @(negedge clk);
    check("line_break", line_break, 1'b1);
    check("rd_valid", rd_valid, 1'b0);  // nothing written
    idle_line(bit_period);
    @(negedge clk);
    check("line_break", line_break, 1'b0);
    random_byte(b);
    receive_byte(b);
    read_bytes(1);

    // 4 clock glitch to be rejected at mid start bit
    @(posedge clk);
    rx <= 1'b0;
    repeat (4) @(posedge clk);
    rx <= 1'b1;
    idle_line(11 * bit_period);  // longer than a whole frame
    @(negedge clk);
    check("rd_valid", rd_valid, 1'b0);
    check("line_break", line_break, 1'b0);
    random_byte(b);
    receive_byte(b);
    read_bytes(1);

    // one frame more than the FIFO holds so the last one is lost
    for (int i = 0; i < fifo_depth; i++)
    begin
      random_byte(b);
      receive_byte(b);
    end
    random_byte(b);
    send_frame(b, 1'b1);
    @(negedge clk);
    check("overflow", overflow, 1'b1);
    check("line_break", line_break, 1'b0);
    read_bytes(fifo_depth);  // first eight intact
    check("overflow", overflow, 1'b1);  // sticky

    $display("Simulation completed successfully");
    $finish;
  end

endmodule : tb_uart

//--- list.f
rtl/uart_pkg.sv
rtl/serial_rx.sv
rtl/serial_tx.sv
rtl/rx_fifo.sv
rtl/uart_core.sv
dv/tb_clock.sv
dv/tb_uart.sv

//--- rtl/rx_fifo.sv
// show-ahead buffer for received bytes, fifo_depth entries
// head byte is always on rd_data, rd_valid means not empty
// writes never stall; a write while full is lost and sets sticky overflow

module rx_fifo (
  input  logic       clk,       // system clock
  input  logic       reset,     // sync, active high
  input  logic       wr_en,     // write strobe from the receiver
  input  logic [7:0] wr_data,   // byte to store
  input  logic       rd_en,     // pop head, ignored when empty
  output logic [7:0] rd_data,   // head byte
  output logic       rd_valid,  // buffer not empty
  output logic       overflow   // byte dropped since reset
);

  import uart_pkg::*;

  logic [7:0]                 mem [fifo_depth];  // storage, no reset
  logic [fifo_addr_width-1:0] wr_ptr;            // next free slot
  logic [fifo_addr_width-1:0] rd_ptr;            // head slot
  logic [fifo_addr_width:0]   count;             // entries held
  logic                       full;
  logic                       do_wr;
  logic                       do_rd;

  assign full     = (count == (fifo_addr_width + 1)'(fifo_depth));
  assign do_wr    = wr_en && !full;
  assign do_rd    = rd_en && rd_valid;
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];  // show-ahead

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;  // both at once, count unchanged
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      overflow <= 1'b0;
    else if (wr_en && full)
      overflow <= 1'b1;  // sticky until reset
  end

endmodule : rx_fifo

//--- rtl/serial_rx.sv
// serial receiver, fixed rate, 8 data bits, one stop bit, no parity
// samples mid-bit off a countdown timer started at the falling start edge
// ready pulses one clock per good byte; line_break flags a low stop bit

module serial_rx (
  input  logic       clk,         // system clock
  input  logic       reset,       // sync, active high
  input  logic       rx,          // serial line, asynchronous
  output logic       line_break,  // bad stop bit seen, held until line idle
  output logic       ready,       // one-cycle strobe, data valid
  output logic [7:0] data         // last received byte
);

  import uart_pkg::*;

  logic [2:0]             sync;   // synchronizer chain
  logic                   rx_in;  // synchronized line
  logic [timer_width-1:0] timer;  // bit timer, counts down
  logic [3:0]             bits;   // 0 idle, 1 start, 2..9 data, 10 stop

  // three flops against metastability
  always_ff @(posedge clk)
  begin
    if (reset)
      sync <= {3{idle_bit}};  // line assumed at rest
    else
      sync <= {sync[1:0], rx};
  end

  assign rx_in = sync[2];

  // receive fsm, timer and bit counter in one block
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      timer      <= '0;
      bits       <= 4'd0;
      ready      <= 1'b0;
      line_break <= 1'b0;
    end
    else
    begin
      ready <= 1'b0;  // strobe, default low
      if (timer != '0)
        timer <= timer - 1'b1;  // wait for mid-bit
      else if (bits != 4'd0)
      begin
        if ((bits == 4'd1) && (rx_in != start_bit))
          bits <= 4'd0;  // false start, back to idle
        else if (bits == 4'd10)
        begin
          if (rx_in == stop_bit)
            ready <= 1'b1;  // good frame
          else
            line_break <= 1'b1;  // framing error or break
          bits <= 4'd0;
        end
        else
        begin
          // start bit is shifted in too, and out again by the 8th data bit
          bits  <= bits + 1'b1;
          timer <= timer_width'(full_bit_time);  // next sample one bit later
        end
      end
      else if (line_break && (rx_in == idle_bit))
        line_break <= 1'b0;  // line back at rest
      else if (rx_in == start_bit)
      begin
        timer <= timer_width'(half_bit_time);  // go to middle of start bit
        bits  <= 4'd1;
      end
    end
  end

  // data shifter, lsb arrives first
  always_ff @(posedge clk)
  begin
    if ((timer == '0) && (bits != 4'd0) && (bits != 4'd10))
    begin
      if ((bits != 4'd1) || (rx_in == start_bit))
        data <= {rx_in, data[7:1]};  // shift right, new bit on top
    end
  end

endmodule : serial_rx

//--- rtl/serial_tx.sv
// serial transmitter, fixed rate, one start bit, 8 data bits, one stop bit
// a tx_start pulse while idle loads a frame; tx_busy is high until the
// stop bit has been on the line for a whole bit

module serial_tx (
  input  logic       clk,       // system clock
  input  logic       reset,     // sync, active high
  input  logic [7:0] tx_data,   // byte to send, taken with tx_start
  input  logic       tx_start,  // one-cycle start, ignored while busy
  output logic       tx_busy,   // frame in progress
  output logic       tx         // serial line out
);

  import uart_pkg::*;

  logic [9:0]             frame;  // bits still to go, bit 0 on the line
  logic [timer_width-1:0] timer;  // bit timer, counts down
  logic [3:0]             bits;   // bits left incl. current, 0 when idle

  assign tx      = frame[0];
  assign tx_busy = (bits != 4'd0);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      frame <= {10{idle_bit}};  // line rests high
      timer <= '0;
      bits  <= 4'd0;
    end
    else if (bits == 4'd0)
    begin
      if (tx_start)
      begin
        frame <= {stop_bit, tx_data, start_bit};  // start bit goes out now
        timer <= timer_width'(full_bit_time);
        bits  <= 4'd10;
      end
    end
    else if (timer != '0)
      timer <= timer - 1'b1;  // hold current bit
    else
    begin
      // shift in idle level, so the line rests high after the stop bit
      frame <= {idle_bit, frame[9:1]};
      timer <= timer_width'(full_bit_time);
      bits  <= bits - 1'b1;  // reaching 0 ends busy
    end
  end

endmodule : serial_tx

//--- rtl/uart_core.sv
// uart top level: receiver into an 8-byte read buffer, plus a transmitter
// host pops received bytes with rd_en and sends with tx_data/tx_start

module uart_core (
  input  logic       clk,         // system clock
  input  logic       reset,       // sync, active high
  input  logic       rx,          // serial in, asynchronous
  output logic       tx,          // serial out
  input  logic [7:0] tx_data,     // byte to send
  input  logic       tx_start,    // send strobe, dropped while busy
  output logic       tx_busy,     // transmitter active
  output logic [7:0] rd_data,     // oldest received byte
  output logic       rd_valid,    // rd_data holds a byte
  input  logic       rd_en,       // pop, same cycle
  output logic       line_break,  // bad stop bit, cleared by idle line
  output logic       overflow     // received byte lost, sticky
);

  logic       rx_ready;  // byte strobe, receiver to buffer
  logic [7:0] rx_data;   // received byte

  serial_rx u_rx (
    .clk        (clk),
    .reset      (reset),
    .rx         (rx),
    .line_break (line_break),  // straight out as status
    .ready      (rx_ready),
    .data       (rx_data)
  );

  // receiver is never held off; host must keep up
  rx_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (rx_ready),
    .wr_data  (rx_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .overflow (overflow)
  );

  // start pulse goes in ungated, the transmitter drops it while busy
  serial_tx u_tx (
    .clk      (clk),
    .reset    (reset),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

endmodule : uart_core

//--- rtl/uart_pkg.sv
// shared constants for the uart subsystem: bit rate, bit timer reloads,
// line levels and receive buffer sizing
// imported by the receiver, the transmitter and the receive buffer

package uart_pkg;

  // clock and line rate
  localparam int unsigned clk_freq = 25_000_000;   // system clock in hz
  localparam int unsigned bit_freq = 1_562_500;    // line rate in bit/s

  // bit timing, derived from the two rates above
  localparam int unsigned bit_period = clk_freq / bit_freq;  // clocks per bit, 16
  localparam int unsigned full_bit_time = bit_period - 1;    // reload for a whole bit
  localparam int unsigned half_bit_time = full_bit_time >> 1; // start edge to mid-bit

  // countdown timer width, enough to hold full_bit_time
  localparam int timer_width = $clog2(bit_period);

  // line levels of the frame
  localparam logic idle_bit = 1'b1;   // line at rest
  localparam logic start_bit = 1'b0;  // first bit of a frame
  localparam logic stop_bit = 1'b1;   // last bit of a frame

  // receive buffer
  localparam int unsigned fifo_depth = 8;                // entries, power of two
  localparam int fifo_addr_width = $clog2(fifo_depth);   // pointer width

  // frame layout: one start bit, eight data bits lsb first, one stop bit
  //   bit 0     start_bit
  //   bit 1..8  data[0]..data[7]
  //   bit 9     stop_bit
  // one frame therefore takes 10 bit periods, 160 clocks at these rates

endpackage : uart_pkg
